/* Bender.yml */
package:
  name: rs_top

sources:
  - hdl/rs_pkg.sv
  - hdl/op_translate.sv
  - hdl/rename_table.sv
  - hdl/rs_entries.sv
  - hdl/alu_stage.sv
  - hdl/rs_top.sv
  - target: test
    files:
      - tests/rs_top_asserts.sv
      - tests/rs_top_tb.sv

/* hdl/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage
    import rs_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              clear,
    input  logic              issue_valid,
    input  logic [XLEN-1:0]   issue_a,
    input  logic [XLEN-1:0]   issue_b,
    input  logic [ALU_W-1:0]  issue_op,
    input  logic [REG_W-1:0]  issue_rd,
    input  logic [SLOT_W-1:0] issue_slot,
    output logic              result_valid,
    output logic [REG_W-1:0]  result_rd,
    output logic [XLEN-1:0]   result_data,
    output logic [SLOT_W-1:0] result_slot
);

    logic [XLEN-1:0]    alu_out;
    logic [SHAMT_W-1:0] shamt;

    assign shamt = issue_b[SHAMT_W-1:0];

    always_comb begin
        case (issue_op)
            ALU_ADD:  alu_out = issue_a + issue_b;
            ALU_SUB:  alu_out = issue_a - issue_b;
            ALU_AND:  alu_out = issue_a & issue_b;
            ALU_OR:   alu_out = issue_a | issue_b;
            ALU_XOR:  alu_out = issue_a ^ issue_b;
            ALU_SLL:  alu_out = issue_a << shamt;
            ALU_SRL:  alu_out = issue_a >> shamt;
            ALU_SRA:  alu_out = $signed(issue_a) >>> shamt;
            ALU_SLT:  alu_out = XLEN'($signed(issue_a) < $signed(issue_b));
            ALU_SLTU: alu_out = XLEN'(issue_a < issue_b);
            default:  alu_out = '0;
        endcase
    end

    // One-cycle broadcast
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in)
            result_valid <= 1'b0;
        else
            result_valid <= issue_valid && !clear;
    end

    always_ff @(posedge clk_in) begin
        if (issue_valid) begin
            result_data <= alu_out;
            result_rd   <= issue_rd;
            result_slot <= issue_slot;
        end
    end

endmodule

/* hdl/op_translate.sv */
`timescale 1ns/1ps

module op_translate
    import rs_pkg::*;
(
    input  logic [OP_W-1:0]  op,
    output logic [ALU_W-1:0] alu_op,
    output logic             use_rs1,
    output logic             use_rs2,
    output logic             a_from_pc,
    output logic             b_from_imm
);

    logic reg_form;
    logic imm_form;

    assign reg_form = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                 OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
    assign imm_form = op inside {OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLLI,
                                 OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU};

    // Operand sources
    assign use_rs1    = reg_form || imm_form;   // LUI leaves a at zero
    assign use_rs2    = reg_form;
    assign a_from_pc  = (op == OP_AUIPC);
    assign b_from_imm = imm_form || (op == OP_AUIPC) || (op == OP_LUI);

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI, OP_AUIPC, OP_LUI: alu_op = ALU_ADD;
            OP_SUB:                            alu_op = ALU_SUB;
            OP_AND, OP_ANDI:                   alu_op = ALU_AND;
            OP_OR, OP_ORI:                     alu_op = ALU_OR;
            OP_XOR, OP_XORI:                   alu_op = ALU_XOR;
            OP_SLL, OP_SLLI:                   alu_op = ALU_SLL;
            OP_SRL, OP_SRLI:                   alu_op = ALU_SRL;
            OP_SRA, OP_SRAI:                   alu_op = ALU_SRA;
            OP_SLT, OP_SLTI:                   alu_op = ALU_SLT;
            OP_SLTU, OP_SLTIU:                 alu_op = ALU_SLTU;
            default:                           alu_op = ALU_ADD;  // Illegal, no sources
        endcase
    end

endmodule

/* hdl/rename_table.sv */
`timescale 1ns/1ps

module rename_table
    import rs_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              clear,
    input  logic [REG_W-1:0]  rs1,
    input  logic [REG_W-1:0]  rs2,
    input  logic              alloc,
    input  logic [REG_W-1:0]  alloc_rd,
    input  logic [SLOT_W-1:0] alloc_slot,
    input  logic              bcast_valid,
    input  logic [REG_W-1:0]  bcast_rd,
    input  logic [SLOT_W-1:0] bcast_slot,
    output logic              rs1_hit,
    output logic              rs2_hit,
    output logic [SLOT_W-1:0] rs1_slot,
    output logic [SLOT_W-1:0] rs2_slot
);

    logic [NUM_REGS-1:0] map_busy;
    logic [SLOT_W-1:0]   map_slot [NUM_REGS];
    logic                map_write;
    logic                map_release;

    assign rs1_hit  = map_busy[rs1];
    assign rs2_hit  = map_busy[rs2];
    assign rs1_slot = map_slot[rs1];
    assign rs2_slot = map_slot[rs2];

    assign map_write   = alloc && (alloc_rd != '0);   // x0 never mapped
    // Only the youngest producer releases the mapping
    assign map_release = bcast_valid && map_busy[bcast_rd]
                         && (map_slot[bcast_rd] == bcast_slot)
                         && !(alloc && (alloc_rd == bcast_rd));

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            map_busy <= '0;
        end else if (clear) begin
            map_busy <= '0;
        end else begin
            if (map_release)
                map_busy[bcast_rd] <= 1'b0;
            if (map_write)
                map_busy[alloc_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (map_write)
            map_slot[alloc_rd] <= alloc_slot;
    end

endmodule

/* hdl/rs_entries.sv */
`timescale 1ns/1ps

module rs_entries
    import rs_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              clear,
    input  logic              dispatch_valid,
    input  logic [OP_W-1:0]   dispatch_op,
    input  logic [REG_W-1:0]  dispatch_rd,
    input  logic [XLEN-1:0]   dispatch_imm,
    input  logic [XLEN-1:0]   dispatch_pc,
    input  logic [XLEN-1:0]   reg_rdata1,
    input  logic [XLEN-1:0]   reg_rdata2,
    input  logic              rs1_hit,
    input  logic              rs2_hit,
    input  logic [SLOT_W-1:0] rs1_slot,
    input  logic [SLOT_W-1:0] rs2_slot,
    input  logic              bcast_valid,
    input  logic [SLOT_W-1:0] bcast_slot,
    input  logic [XLEN-1:0]   bcast_data,
    output logic              dispatch_ready,
    output logic              alloc,
    output logic [SLOT_W-1:0] alloc_slot,
    output logic              issue_valid,
    output logic [XLEN-1:0]   issue_a,
    output logic [XLEN-1:0]   issue_b,
    output logic [ALU_W-1:0]  issue_op,
    output logic [REG_W-1:0]  issue_rd,
    output logic [SLOT_W-1:0] issue_slot
);

    logic [RS_SIZE-1:0] busy, issued, a_rdy, b_rdy, a_wake, b_wake;
    logic [ALU_W-1:0]   op_q  [RS_SIZE];
    logic [REG_W-1:0]   rd_q  [RS_SIZE];
    logic [XLEN-1:0]    a_val [RS_SIZE];
    logic [XLEN-1:0]    b_val [RS_SIZE];
    logic [SLOT_W-1:0]  a_tag [RS_SIZE];
    logic [SLOT_W-1:0]  b_tag [RS_SIZE];

    logic [ALU_W-1:0]  new_op;
    logic              use_rs1, use_rs2, a_from_pc, b_from_imm;
    logic [XLEN-1:0]   a_new, b_new;
    logic              a_new_rdy, b_new_rdy;
    logic              free_found, sel_found;
    logic [SLOT_W-1:0] free_slot, sel_slot;

    op_translate op_translate_i (
        .op         (dispatch_op),
        .alu_op     (new_op),
        .use_rs1    (use_rs1),
        .use_rs2    (use_rs2),
        .a_from_pc  (a_from_pc),
        .b_from_imm (b_from_imm)
    );

    // ********************
    // Allocation and select
    // ********************
    always_comb begin
        free_found = 1'b0;
        free_slot  = '0;
        sel_found  = 1'b0;
        sel_slot   = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin  // Lowest index wins
            if (!busy[i]) begin
                free_found = 1'b1;
                free_slot  = SLOT_W'(i);
            end
            if (busy[i] && !issued[i] && a_rdy[i] && b_rdy[i]) begin
                sel_found = 1'b1;
                sel_slot  = SLOT_W'(i);
            end
        end
    end

    assign dispatch_ready = free_found;
    assign alloc          = dispatch_valid && free_found;
    assign alloc_slot     = free_slot;

    // Operand capture at dispatch
    always_comb begin
        a_new     = '0;
        a_new_rdy = 1'b1;
        if (!use_rs1) begin
            a_new = a_from_pc ? dispatch_pc : '0;
        end else if (!rs1_hit) begin
            a_new = reg_rdata1;
        end else if (bcast_valid && (bcast_slot == rs1_slot)) begin
            a_new = bcast_data;   // Producer broadcasting now
        end else begin
            a_new_rdy = 1'b0;
        end
    end

    always_comb begin
        b_new     = '0;
        b_new_rdy = 1'b1;
        if (!use_rs2) begin
            b_new = b_from_imm ? dispatch_imm : '0;
        end else if (!rs2_hit) begin
            b_new = reg_rdata2;
        end else if (bcast_valid && (bcast_slot == rs2_slot)) begin
            b_new = bcast_data;
        end else begin
            b_new_rdy = 1'b0;
        end
    end

    // Wakeup on matching broadcast
    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            a_wake[i] = bcast_valid && busy[i] && !a_rdy[i] && (a_tag[i] == bcast_slot);
            b_wake[i] = bcast_valid && busy[i] && !b_rdy[i] && (b_tag[i] == bcast_slot);
        end
    end

    // ********************
    // Entry state
    // ********************
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            busy        <= '0;
            issued      <= '0;
            a_rdy       <= '0;
            b_rdy       <= '0;
            issue_valid <= 1'b0;
        end else if (clear) begin
            busy        <= '0;
            issue_valid <= 1'b0;
        end else begin
            a_rdy <= a_rdy | a_wake;
            b_rdy <= b_rdy | b_wake;
            if (bcast_valid)
                busy[bcast_slot] <= 1'b0;  // Slot retires with its broadcast
            issue_valid <= sel_found;
            if (sel_found)
                issued[sel_slot] <= 1'b1;
            if (alloc) begin
                busy[free_slot]   <= 1'b1;
                issued[free_slot] <= 1'b0;
                a_rdy[free_slot]  <= a_new_rdy;
                b_rdy[free_slot]  <= b_new_rdy;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (a_wake[i])
                a_val[i] <= bcast_data;
            if (b_wake[i])
                b_val[i] <= bcast_data;
        end
        if (sel_found) begin
            issue_a    <= a_val[sel_slot];
            issue_b    <= b_val[sel_slot];
            issue_op   <= op_q[sel_slot];
            issue_rd   <= rd_q[sel_slot];
            issue_slot <= sel_slot;
        end
        if (alloc) begin
            op_q[free_slot]  <= new_op;
            rd_q[free_slot]  <= dispatch_rd;
            a_val[free_slot] <= a_new;
            b_val[free_slot] <= b_new;
            a_tag[free_slot] <= rs1_slot;
            b_tag[free_slot] <= rs2_slot;
        end
    end

endmodule

/* hdl/rs_pkg.sv */
package rs_pkg;

    // ********************
    // Widths
    // ********************
    localparam int XLEN     = 32;
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;
    localparam int RS_SIZE  = 4;
    localparam int SLOT_W   = 2;
    localparam int SHAMT_W  = 5;   // Shift amount bits taken from b

    // ********************
    // Internal opcodes
    // ********************
    localparam int OP_W = 6;

    localparam logic [OP_W-1:0] OP_ADD   = 6'b000000;
    localparam logic [OP_W-1:0] OP_SUB   = 6'b000001;
    localparam logic [OP_W-1:0] OP_AND   = 6'b000010;
    localparam logic [OP_W-1:0] OP_OR    = 6'b000011;
    localparam logic [OP_W-1:0] OP_XOR   = 6'b000100;
    localparam logic [OP_W-1:0] OP_SLL   = 6'b000101;
    localparam logic [OP_W-1:0] OP_SRL   = 6'b000110;
    localparam logic [OP_W-1:0] OP_SRA   = 6'b000111;
    localparam logic [OP_W-1:0] OP_SLT   = 6'b001000;
    localparam logic [OP_W-1:0] OP_SLTU  = 6'b001001;
    localparam logic [OP_W-1:0] OP_ADDI  = 6'b001010;
    localparam logic [OP_W-1:0] OP_ANDI  = 6'b001011;
    localparam logic [OP_W-1:0] OP_ORI   = 6'b001100;
    localparam logic [OP_W-1:0] OP_XORI  = 6'b001101;
    localparam logic [OP_W-1:0] OP_SLLI  = 6'b001110;
    localparam logic [OP_W-1:0] OP_SRLI  = 6'b001111;
    localparam logic [OP_W-1:0] OP_SRAI  = 6'b010000;
    localparam logic [OP_W-1:0] OP_SLTI  = 6'b010001;
    localparam logic [OP_W-1:0] OP_SLTIU = 6'b010010;
    localparam logic [OP_W-1:0] OP_AUIPC = 6'b100011;
    localparam logic [OP_W-1:0] OP_LUI   = 6'b100100;

    // ********************
    // ALU operations
    // ********************
    localparam int ALU_W = 4;

    localparam logic [ALU_W-1:0] ALU_ADD  = 4'b0000;
    localparam logic [ALU_W-1:0] ALU_SUB  = 4'b0001;
    localparam logic [ALU_W-1:0] ALU_AND  = 4'b0010;
    localparam logic [ALU_W-1:0] ALU_OR   = 4'b0011;
    localparam logic [ALU_W-1:0] ALU_XOR  = 4'b0100;
    localparam logic [ALU_W-1:0] ALU_SLL  = 4'b0101;
    localparam logic [ALU_W-1:0] ALU_SRL  = 4'b0110;
    localparam logic [ALU_W-1:0] ALU_SRA  = 4'b0111;
    localparam logic [ALU_W-1:0] ALU_SLT  = 4'b1000;
    localparam logic [ALU_W-1:0] ALU_SLTU = 4'b1001;

endpackage

/* hdl/rs_top.sv */
`timescale 1ns/1ps

module rs_top
    import rs_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              clear,
    input  logic              dispatch_valid,
    input  logic [OP_W-1:0]   dispatch_op,
    input  logic [REG_W-1:0]  dispatch_rd,
    input  logic [REG_W-1:0]  dispatch_rs1,
    input  logic [REG_W-1:0]  dispatch_rs2,
    input  logic [XLEN-1:0]   dispatch_imm,
    input  logic [XLEN-1:0]   dispatch_pc,
    input  logic [XLEN-1:0]   reg_rdata1,
    input  logic [XLEN-1:0]   reg_rdata2,
    output logic              dispatch_ready,
    output logic              result_valid,
    output logic [REG_W-1:0]  result_rd,
    output logic [XLEN-1:0]   result_data,
    output logic [SLOT_W-1:0] result_slot
);

    logic              rs1_hit, rs2_hit;
    logic [SLOT_W-1:0] rs1_slot, rs2_slot;
    logic              alloc;
    logic [SLOT_W-1:0] alloc_slot;
    logic              issue_valid;
    logic [XLEN-1:0]   issue_a, issue_b;
    logic [ALU_W-1:0]  issue_op;
    logic [REG_W-1:0]  issue_rd;
    logic [SLOT_W-1:0] issue_slot;

    rename_table rename_table_i (
        .clk_in, .rst_in, .clear,
        .rs1         (dispatch_rs1),
        .rs2         (dispatch_rs2),
        .alloc, .alloc_slot,
        .alloc_rd    (dispatch_rd),
        .bcast_valid (result_valid),
        .bcast_rd    (result_rd),
        .bcast_slot  (result_slot),
        .rs1_hit, .rs2_hit, .rs1_slot, .rs2_slot
    );

    rs_entries rs_entries_i (
        .clk_in, .rst_in, .clear,
        .dispatch_valid, .dispatch_op, .dispatch_rd, .dispatch_imm, .dispatch_pc,
        .reg_rdata1, .reg_rdata2,
        .rs1_hit, .rs2_hit, .rs1_slot, .rs2_slot,
        .bcast_valid (result_valid),   // Broadcast loops back
        .bcast_slot  (result_slot),
        .bcast_data  (result_data),
        .dispatch_ready, .alloc, .alloc_slot,
        .issue_valid, .issue_a, .issue_b, .issue_op, .issue_rd, .issue_slot
    );

    alu_stage alu_stage_i (
        .clk_in, .rst_in, .clear,
        .issue_valid, .issue_a, .issue_b, .issue_op, .issue_rd, .issue_slot,
        .result_valid, .result_rd, .result_data, .result_slot
    );

endmodule

/* tests/rs_top_asserts.sv */
`timescale 1ns/1ps

module rs_top_asserts
    import rs_pkg::*;
(
    input logic              clk_in,
    input logic              rst_in,
    input logic              clear,
    input logic              dispatch_valid,
    input logic              dispatch_ready,
    input logic              result_valid,
    input logic [SLOT_W-1:0] result_slot
);

    logic [SLOT_W:0] in_flight;   // Accepted and not yet broadcast

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            in_flight <= '0;
        end else if (clear) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + (SLOT_W+1)'(dispatch_valid && dispatch_ready)
                         - (SLOT_W+1)'(result_valid);
        end
    end

    // One broadcast per slot, never back to back
    a_single_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
        result_valid |=> !(result_valid && (result_slot == $past(result_slot))))
        else $error("result_valid held two cycles for slot %0d", result_slot);

    a_quiet_in_reset: assert property (@(posedge clk_in)
        rst_in |-> !result_valid)
        else $error("result_valid high during reset");

    a_no_alloc_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
        (in_flight == (SLOT_W+1)'(RS_SIZE)) |-> !(dispatch_valid && dispatch_ready))
        else $error("dispatch accepted with all entries busy");

endmodule

bind rs_top rs_top_asserts rs_top_asserts_i (.*);

/* tests/rs_top_tb.sv */
`timescale 1ns/1ps

module rs_top_tb
    import rs_pkg::*;
();

    localparam int TIMEOUT = 200;   // Cycles per wait
    localparam int SEED    = 38;

    logic              clk_in;
    logic              rst_in;
    logic              clear;
    logic              dispatch_valid;
    logic [OP_W-1:0]   dispatch_op;
    logic [REG_W-1:0]  dispatch_rd;
    logic [REG_W-1:0]  dispatch_rs1;
    logic [REG_W-1:0]  dispatch_rs2;
    logic [XLEN-1:0]   dispatch_imm;
    logic [XLEN-1:0]   dispatch_pc;
    logic [XLEN-1:0]   reg_rdata1;
    logic [XLEN-1:0]   reg_rdata2;
    logic              dispatch_ready;
    logic              result_valid;
    logic [REG_W-1:0]  result_rd;
    logic [XLEN-1:0]   result_data;
    logic [SLOT_W-1:0] result_slot;

    logic [XLEN-1:0]   regs  [NUM_REGS];   // Architectural state
    logic [XLEN-1:0]   mregs [NUM_REGS];   // Program-order model
    logic [REG_W-1:0]  exp_rd[$];
    logic [XLEN-1:0]   exp_data[$];
    logic [SLOT_W-1:0] exp_slot[$];
    logic [REG_W-1:0]  retired[$];
    logic              held_valid;   // Slot still busy until the next edge
    logic [SLOT_W-1:0] held_slot;
    logic              full_seen;
    integer            seed;
    int                errors;
    int                checks;
    int                tests_run;

    logic [OP_W-1:0] kept_ops [21] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL,
        OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLLI,
        OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU, OP_AUIPC, OP_LUI};

    rs_top rs_top_i (.*);

    assign reg_rdata1 = regs[dispatch_rs1];
    assign reg_rdata2 = regs[dispatch_rs2];

    always #4 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        if (result_valid && (result_rd != '0))
            regs[result_rd] <= result_data;   // Retire into register array
    end

    always @(negedge clk_in) begin
        held_valid = 1'b0;
        if (!rst_in && result_valid)
            take_result();
        if (!rst_in && !dispatch_ready)
            full_seen = 1'b1;
    end

    // ********************
    // Checks and model
    // ********************
    task automatic check_data(input string name, input logic [XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rd(input string name, input logic [REG_W-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_slot(input string name, input logic [SLOT_W-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [XLEN-1:0] model_result(input logic [OP_W-1:0] op,
                                                    input logic [XLEN-1:0] a, b, imm, pc);
        logic [XLEN-1:0] y;
        case (op)
            OP_ADD:   y = a + b;
            OP_SUB:   y = a - b;
            OP_AND:   y = a & b;
            OP_OR:    y = a | b;
            OP_XOR:   y = a ^ b;
            OP_SLL:   y = a << b[4:0];
            OP_SRL:   y = a >> b[4:0];
            OP_SRA:   y = $signed(a) >>> b[4:0];
            OP_SLT:   y = XLEN'($signed(a) < $signed(b));
            OP_SLTU:  y = XLEN'(a < b);
            OP_ADDI:  y = a + imm;
            OP_ANDI:  y = a & imm;
            OP_ORI:   y = a | imm;
            OP_XORI:  y = a ^ imm;
            OP_SLLI:  y = a << imm[4:0];
            OP_SRLI:  y = a >> imm[4:0];
            OP_SRAI:  y = $signed(a) >>> imm[4:0];
            OP_SLTI:  y = XLEN'($signed(a) < $signed(imm));
            OP_SLTIU: y = XLEN'(a < imm);
            OP_AUIPC: y = pc + imm;
            OP_LUI:   y = imm;
            default:  y = 'x;
        endcase
        return y;
    endfunction

    // Match by rd, so independent results may retire out of order
    task automatic take_result();
        int idx;
        idx = -1;
        for (int i = exp_rd.size() - 1; i >= 0; i--) begin
            if (exp_rd[i] == result_rd)
                idx = i;
        end
        if (exp_rd.size() == 0) begin
            errors++;
            $display("Result for register %0d arrived with nothing outstanding", result_rd);
        end else if (idx < 0) begin
            check_rd("result_rd", result_rd, exp_rd[0]);
        end else begin
            check_data("result_data", result_data, exp_data[idx]);
            check_slot("result_slot", result_slot, exp_slot[idx]);
            held_valid = 1'b1;
            held_slot  = exp_slot[idx];
            exp_rd.delete(idx);
            exp_data.delete(idx);
            exp_slot.delete(idx);
            retired.push_back(result_rd);
        end
    endtask

    function automatic logic is_pending(input logic [REG_W-1:0] rd);
        foreach (exp_rd[i]) begin
            if (exp_rd[i] == rd)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic in_order(input logic [REG_W-1:0] first, second);
        int pf;
        int ps;
        pf = -1;
        ps = -1;
        foreach (retired[i]) begin
            if ((retired[i] == first) && (pf < 0))
                pf = i;
            if ((retired[i] == second) && (ps < 0))
                ps = i;
        end
        return (pf >= 0) && (ps > pf);
    endfunction

    // ********************
    // Driving and waiting
    // ********************
    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s after %0d cycles", what, TIMEOUT);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic send(input logic [OP_W-1:0] op, input logic [REG_W-1:0] rd, rs1, rs2,
                        input logic [XLEN-1:0] imm, pc);
        int n;
        int free_idx;
        logic [XLEN-1:0] expect_val;
        logic [RS_SIZE-1:0] taken;
        n = 0;
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_rd    = rd;
        dispatch_rs1   = rs1;
        dispatch_rs2   = rs2;
        dispatch_imm   = imm;
        dispatch_pc    = pc;
        @(negedge clk_in);
        while (!dispatch_ready) begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("dispatch_ready stayed low");
            @(negedge clk_in);
        end
        @(posedge clk_in);   // Accepted here
        taken = '0;
        foreach (exp_slot[i])
            taken[exp_slot[i]] = 1'b1;
        if (held_valid)
            taken[held_slot] = 1'b1;   // Broadcasting slot frees at this edge
        free_idx = 0;
        while ((free_idx < RS_SIZE - 1) && taken[free_idx])
            free_idx++;
        expect_val = model_result(op, mregs[rs1], mregs[rs2], imm, pc);
        exp_rd.push_back(rd);
        exp_data.push_back(expect_val);
        exp_slot.push_back(SLOT_W'(free_idx));
        if (rd != '0)
            mregs[rd] = expect_val;
        #1;
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (exp_rd.size() != 0) begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("results still outstanding");
            @(negedge clk_in);
        end
        @(posedge clk_in);
        #1;
    endtask

    task automatic compare_regs();
        for (int i = 0; i < NUM_REGS; i++)
            check_data($sformatf("regs[%0d]", i), regs[i], mregs[i]);
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - err0);
    endtask

    // ********************
    // Tests
    // ********************
    task automatic reset_test();
        int err0;
        err0 = errors;
        check_flag("dispatch_ready", dispatch_ready, 1'b1);
        repeat (3) begin
            @(negedge clk_in);
            check_flag("result_valid", result_valid, 1'b0);
        end
        @(posedge clk_in);
        #1;
        report_test("reset state", err0);
    endtask

    task automatic opcode_test();
        int err0;
        err0 = errors;
        for (int k = 0; k < 21; k++) begin
            send(kept_ops[k], 5'd9, 5'd3, 5'd7, 32'hffff_f800 | XLEN'(k * 5),
                 32'h0000_1000 + XLEN'(k * 4));
            repeat (2) begin
                @(negedge clk_in);
                check_flag("result_valid", result_valid, 1'b0);
            end
            @(negedge clk_in);
            check_flag("result_valid", result_valid, 1'b1);   // Two cycles after accept
            wait_idle();
        end
        report_test("opcodes", err0);
    endtask

    task automatic chain_test();
        int err0;
        err0 = errors;
        retired.delete();
        send(OP_ADD,  5'd20, 5'd1,  5'd2,  '0, '0);
        send(OP_XOR,  5'd21, 5'd20, 5'd3,  '0, '0);
        send(OP_ANDI, 5'd23, 5'd5,  5'd0,  32'h0f0f_00ff, '0);
        send(OP_SUB,  5'd22, 5'd21, 5'd4,  '0, '0);
        send(OP_ORI,  5'd24, 5'd6,  5'd0,  32'h0000_0a50, '0);
        send(OP_SLTU, 5'd19, 5'd22, 5'd20, '0, '0);
        wait_idle();
        check_flag("chain_order", in_order(5'd20, 5'd21) && in_order(5'd21, 5'd22)
                   && in_order(5'd22, 5'd19), 1'b1);
        compare_regs();
        report_test("dependent chain", err0);
    endtask

    task automatic fill_test();
        int err0;
        err0 = errors;
        full_seen = 1'b0;
        for (int k = 0; k < 6; k++)
            send(OP_ADDI, REG_W'(25 + k), (k == 0) ? 5'd8 : REG_W'(24 + k), 5'd0,
                 XLEN'(3 * k + 1), '0);
        wait_idle();
        check_flag("full_seen", full_seen, 1'b1);
        check_flag("dispatch_ready", dispatch_ready, 1'b1);
        compare_regs();
        report_test("full station", err0);
    endtask

    task automatic clear_test();
        int err0;
        err0 = errors;
        send(OP_ADD, 5'd10, 5'd1, 5'd2, '0, '0);
        send(OP_XOR, 5'd11, 5'd10, 5'd3, '0, '0);
        clear = 1'b1;   // Lands before the first result
        @(posedge clk_in);
        #1;
        clear = 1'b0;
        exp_rd.delete();
        exp_data.delete();
        exp_slot.delete();
        mregs = regs;
        repeat (4) @(negedge clk_in);
        check_flag("dispatch_ready", dispatch_ready, 1'b1);
        @(posedge clk_in);
        #1;
        send(OP_ADDI, 5'd12, 5'd10, 5'd0, '0, '0);
        wait_idle();
        compare_regs();
        report_test("clear", err0);
    endtask

    task automatic random_test();
        int err0;
        logic [OP_W-1:0]  op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [XLEN-1:0]  imm;
        logic [XLEN-1:0]  pc;
        err0 = errors;
        for (int k = 0; k < 20; k++) begin
            op  = kept_ops[{$random(seed)} % 21];
            rd  = REG_W'({$random(seed)} % 16);
            rs1 = REG_W'({$random(seed)} % 16);
            rs2 = REG_W'({$random(seed)} % 16);
            imm = $random(seed);
            pc  = $random(seed);
            if (is_pending(rd))
                wait_idle();   // Avoid two writers of one register in flight
            send(op, rd, rs1, rs2, imm, pc);
        end
        wait_idle();
        compare_regs();
        report_test("random", err0);
    endtask

    initial begin
        clk_in         = 1'b0;
        rst_in         = 1'b1;
        clear          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = OP_ADD;
        dispatch_rd    = '0;
        dispatch_rs1   = '0;
        dispatch_rs2   = '0;
        dispatch_imm   = '0;
        dispatch_pc    = '0;
        held_valid     = 1'b0;
        held_slot      = '0;
        full_seen      = 1'b0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        seed           = SEED;
        for (int i = 0; i < NUM_REGS; i++)
            regs[i] = XLEN'(i) * 32'h9e37_79b9;
        mregs = regs;
        repeat (5) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        reset_test();
        opcode_test();
        chain_test();
        fill_test();
        clear_test();
        random_test();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/rs_pkg.sv
hdl/op_translate.sv
hdl/rename_table.sv
hdl/rs_entries.sv
hdl/alu_stage.sv
hdl/rs_top.sv
tests/rs_top_asserts.sv
tests/rs_top_tb.sv
